// ==== common/vcache_pkg.sv ====
package vcache_pkg;

    localparam int LANES  = 2;
    localparam int DATA_W = 32;
    localparam int ROW_W  = 4;   // 16 rows per lane per block
    localparam int BLK_W  = 2;   // room for 4 blocks
    localparam int ADDR_W = BLK_W + ROW_W + 1;
    localparam int TXN_W  = 8;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } opcode_e;

    // host address layout is {block, row, lane}

    function automatic logic [BLK_W-1:0] addr_block(
        input logic [ADDR_W-1:0] addr
    );
        return addr[ADDR_W-1 -: BLK_W];
    endfunction

    function automatic logic [ROW_W-1:0] addr_row(
        input logic [ADDR_W-1:0] addr
    );
        return addr[ROW_W:1];
    endfunction

    function automatic logic addr_lane(
        input logic [ADDR_W-1:0] addr
    );
        return addr[0];
    endfunction

endpackage

// ==== mem_block/bank_sram.sv ====
`timescale 1ns/10ps

module bank_sram (
    input  logic                             clk,

    input  logic                             rd_en   [vcache_pkg::LANES],
    input  logic                             wr_en   [vcache_pkg::LANES],
    input  logic [vcache_pkg::ROW_W-1:0]     row     [vcache_pkg::LANES],
    input  logic [vcache_pkg::DATA_W-1:0]    wr_data [vcache_pkg::LANES],

    output logic [vcache_pkg::DATA_W-1:0]    rd_data [vcache_pkg::LANES]
);
    import vcache_pkg::*;

    localparam int DEPTH = 2 ** ROW_W;

    // one independent single-port array per lane
    for (genvar l = 0; l < LANES; l++) begin : g_bank
        logic [DATA_W-1:0] mem [DEPTH];

        always_ff @(posedge clk) begin
            if (wr_en[l]) begin
                mem[row[l]] <= wr_data[l];
            end
        end

        always_ff @(posedge clk) begin
            if (rd_en[l]) begin
                rd_data[l] <= mem[row[l]];   // held until next read
            end
        end
    end

endmodule

// ==== mem_block/mem_block.sv ====
`timescale 1ns/10ps

module mem_block #(
    parameter int unsigned BLOCK_ID = 0
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             in_vld     [vcache_pkg::LANES],
    input  vcache_pkg::opcode_e              in_opcode  [vcache_pkg::LANES],
    input  logic [vcache_pkg::BLK_W-1:0]     in_blk     [vcache_pkg::LANES],
    input  logic [vcache_pkg::ROW_W-1:0]     in_row     [vcache_pkg::LANES],
    input  logic [vcache_pkg::TXN_W-1:0]     in_txnid   [vcache_pkg::LANES],
    input  logic [vcache_pkg::DATA_W-1:0]    in_data    [vcache_pkg::LANES],
    input  logic                             in_err     [vcache_pkg::LANES],

    output logic                             out_vld    [vcache_pkg::LANES],
    output vcache_pkg::opcode_e              out_opcode [vcache_pkg::LANES],
    output logic [vcache_pkg::BLK_W-1:0]     out_blk    [vcache_pkg::LANES],
    output logic [vcache_pkg::ROW_W-1:0]     out_row    [vcache_pkg::LANES],
    output logic [vcache_pkg::TXN_W-1:0]     out_txnid  [vcache_pkg::LANES],
    output logic [vcache_pkg::DATA_W-1:0]    out_data   [vcache_pkg::LANES],
    output logic                             out_err    [vcache_pkg::LANES]
);
    import vcache_pkg::*;

    localparam logic [BLK_W-1:0] MY_BLK = BLK_W'(BLOCK_ID);

    logic               hit      [LANES];
    logic               rd_en    [LANES];
    logic               wr_en    [LANES];
    logic [DATA_W-1:0]  rd_data  [LANES];
    logic               rd_hit_q [LANES];
    logic [DATA_W-1:0]  data_q   [LANES];

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        // errored items pass through untouched
        assign hit[l]   = in_vld[l] && !in_err[l] && (in_blk[l] == MY_BLK);
        assign rd_en[l] = hit[l] && (in_opcode[l] == OP_READ);
        assign wr_en[l] = hit[l] && (in_opcode[l] == OP_WRITE);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                out_vld[l]  <= 1'b0;
                rd_hit_q[l] <= 1'b0;
            end else begin
                out_vld[l]  <= in_vld[l];
                rd_hit_q[l] <= rd_en[l];
            end
        end

        always_ff @(posedge clk) begin
            if (in_vld[l]) begin
                out_opcode[l] <= in_opcode[l];
                out_blk[l]    <= in_blk[l];
                out_row[l]    <= in_row[l];
                out_txnid[l]  <= in_txnid[l];
                out_err[l]    <= in_err[l];
                data_q[l]     <= in_data[l];
            end
        end

        // sram word lands in the same cycle as the registered item
        assign out_data[l] = rd_hit_q[l] ? rd_data[l] : data_q[l];
    end

    bank_sram u_bank (
        .clk     (clk),
        .rd_en   (rd_en),
        .wr_en   (wr_en),
        .row     (in_row),
        .wr_data (in_data),   // write ack keeps its own data
        .rd_data (rd_data)
    );

endmodule

// ==== src/req_router.sv ====
`timescale 1ns/10ps

module req_router #(
    parameter int unsigned NUM_BLOCKS = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             req_vld,
    input  vcache_pkg::opcode_e              req_opcode,
    input  logic [vcache_pkg::ADDR_W-1:0]    req_addr,
    input  logic [vcache_pkg::DATA_W-1:0]    req_wdata,
    input  logic [vcache_pkg::TXN_W-1:0]     req_txnid,

    output logic                             item_vld    [vcache_pkg::LANES],
    output vcache_pkg::opcode_e              item_opcode [vcache_pkg::LANES],
    output logic [vcache_pkg::BLK_W-1:0]     item_blk    [vcache_pkg::LANES],
    output logic [vcache_pkg::ROW_W-1:0]     item_row    [vcache_pkg::LANES],
    output logic [vcache_pkg::TXN_W-1:0]     item_txnid  [vcache_pkg::LANES],
    output logic [vcache_pkg::DATA_W-1:0]    item_data   [vcache_pkg::LANES],
    output logic                             item_err    [vcache_pkg::LANES]
);
    import vcache_pkg::*;

    logic               lane_sel;
    logic [BLK_W-1:0]   blk;
    logic [ROW_W-1:0]   row;
    logic               blk_bad;
    logic [DATA_W-1:0]  data;

    always_comb begin
        lane_sel = addr_lane(req_addr);
        blk      = addr_block(req_addr);
        row      = addr_row(req_addr);
        blk_bad  = (32'(blk) >= NUM_BLOCKS);   // no block will claim it
        // reads and errored requests carry a zero word
        data     = (req_opcode == OP_WRITE && !blk_bad) ? req_wdata : '0;
    end

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic take;

        assign take = req_vld && (int'(lane_sel) == l);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                item_vld[l] <= 1'b0;
            end else begin
                item_vld[l] <= take;   // other lane drops to 0
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                item_opcode[l] <= req_opcode;
                item_blk[l]    <= blk;
                item_row[l]    <= row;
                item_txnid[l]  <= req_txnid;
                item_data[l]   <= data;
                item_err[l]    <= blk_bad;
            end
        end
    end

endmodule

// ==== src/vcache_ring_top.sv ====
`timescale 1ns/10ps

module vcache_ring_top #(
    parameter int unsigned NUM_BLOCKS = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             req_vld,
    input  vcache_pkg::opcode_e              req_opcode,
    input  logic [vcache_pkg::ADDR_W-1:0]    req_addr,
    input  logic [vcache_pkg::DATA_W-1:0]    req_wdata,
    input  logic [vcache_pkg::TXN_W-1:0]     req_txnid,

    output logic                             rsp_vld    [vcache_pkg::LANES],
    output vcache_pkg::opcode_e              rsp_opcode [vcache_pkg::LANES],
    output logic [vcache_pkg::TXN_W-1:0]     rsp_txnid  [vcache_pkg::LANES],
    output logic [vcache_pkg::DATA_W-1:0]    rsp_data   [vcache_pkg::LANES],
    output logic                             rsp_err    [vcache_pkg::LANES]
);
    import vcache_pkg::*;

    // stage 0 from the router, stage NUM_BLOCKS is the east end
    logic               stg_vld    [NUM_BLOCKS+1][LANES];
    opcode_e            stg_opcode [NUM_BLOCKS+1][LANES];
    logic [BLK_W-1:0]   stg_blk    [NUM_BLOCKS+1][LANES];
    logic [ROW_W-1:0]   stg_row    [NUM_BLOCKS+1][LANES];
    logic [TXN_W-1:0]   stg_txnid  [NUM_BLOCKS+1][LANES];
    logic [DATA_W-1:0]  stg_data   [NUM_BLOCKS+1][LANES];
    logic               stg_err    [NUM_BLOCKS+1][LANES];

    req_router #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_vld     (req_vld),
        .req_opcode  (req_opcode),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_txnid   (req_txnid),
        .item_vld    (stg_vld[0]),
        .item_opcode (stg_opcode[0]),
        .item_blk    (stg_blk[0]),
        .item_row    (stg_row[0]),
        .item_txnid  (stg_txnid[0]),
        .item_data   (stg_data[0]),
        .item_err    (stg_err[0])
    );

    for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_blk
        mem_block #(
            .BLOCK_ID (b)
        ) u_blk (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_vld     (stg_vld[b]),
            .in_opcode  (stg_opcode[b]),
            .in_blk     (stg_blk[b]),
            .in_row     (stg_row[b]),
            .in_txnid   (stg_txnid[b]),
            .in_data    (stg_data[b]),
            .in_err     (stg_err[b]),
            .out_vld    (stg_vld[b+1]),
            .out_opcode (stg_opcode[b+1]),
            .out_blk    (stg_blk[b+1]),
            .out_row    (stg_row[b+1]),
            .out_txnid  (stg_txnid[b+1]),
            .out_data   (stg_data[b+1]),
            .out_err    (stg_err[b+1])
        );
    end

    // blk and row of the last stage have no consumer beyond the chain
    for (genvar l = 0; l < LANES; l++) begin : g_rsp
        assign rsp_vld[l]    = stg_vld[NUM_BLOCKS][l];
        assign rsp_opcode[l] = stg_opcode[NUM_BLOCKS][l];
        assign rsp_txnid[l]  = stg_txnid[NUM_BLOCKS][l];
        assign rsp_data[l]   = stg_data[NUM_BLOCKS][l];
        assign rsp_err[l]    = stg_err[NUM_BLOCKS][l];
    end

endmodule

// ==== tb/vcache_ring_sva.sv ====
`timescale 1ns/10ps

module vcache_ring_sva (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_vld  [vcache_pkg::LANES],
    input  logic    out_vld [vcache_pkg::LANES],
    input  logic    rd_en   [vcache_pkg::LANES],
    input  logic    wr_en   [vcache_pkg::LANES]
);
    import vcache_pkg::*;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        // one cycle per block
        a_vld_forward: assert property (
            @(posedge clk) disable iff (!rst_n) in_vld[l] |=> out_vld[l]
        ) else $error("lane %0d: valid input not forwarded on the next cycle", l);

        a_vld_known: assert property (
            @(posedge clk) disable iff (!rst_n) !$isunknown(out_vld[l])
        ) else $error("lane %0d: out_vld is unknown", l);

        // single-port bank, one access per cycle
        a_one_access: assert property (
            @(posedge clk) disable iff (!rst_n) !(rd_en[l] && wr_en[l])
        ) else $error("lane %0d: read and write enabled together", l);
    end

endmodule

bind mem_block vcache_ring_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_vld  (in_vld),
    .out_vld (out_vld),
    .rd_en   (rd_en),
    .wr_en   (wr_en)
);

// ==== tb/tb_vcache_ring.sv ====
`timescale 1ns/10ps

module tb_vcache_ring;
    import vcache_pkg::*;

    localparam int NUM_BLOCKS   = 3;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int EXP_W        = 2 + TXN_W + DATA_W;   // {opcode, err, txnid, data}
    localparam int VALID_ADDRS  = NUM_BLOCKS * (2 ** (ROW_W + 1));
    localparam int LAT_REQS     = 4;
    localparam int RAND_REQS    = 300;
    localparam int OOR_REQS     = 8;
    localparam int CUT_REQS     = 10;
    localparam int TOTAL_REQS   = 2 * VALID_ADDRS + LAT_REQS + RAND_REQS + OOR_REQS
                                + VALID_ADDRS + CUT_REQS + 4;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + 1000;
    localparam int DRAIN_CYCLES    = 4 * (NUM_BLOCKS + 1) + 8;

    logic               clk;
    logic               rst_n;
    logic               req_vld;
    opcode_e            req_opcode;
    logic [ADDR_W-1:0]  req_addr;
    logic [DATA_W-1:0]  req_wdata;
    logic [TXN_W-1:0]   req_txnid;

    logic               rsp_vld    [LANES];
    opcode_e            rsp_opcode [LANES];
    logic [TXN_W-1:0]   rsp_txnid  [LANES];
    logic [DATA_W-1:0]  rsp_data   [LANES];
    logic               rsp_err    [LANES];

    logic [DATA_W-1:0]  model_mem [2 ** ADDR_W];
    logic [EXP_W-1:0]   exp_q0 [$];
    logic [EXP_W-1:0]   exp_q1 [$];
    logic [31:0]        rng_state;
    int                 checks;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;

    vcache_ring_top #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .req_opcode (req_opcode),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_txnid  (req_txnid),
        .rsp_vld    (rsp_vld),
        .rsp_opcode (rsp_opcode),
        .rsp_txnid  (rsp_txnid),
        .rsp_data   (rsp_data),
        .rsp_err    (rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // expected response; updates the model memory for in-range writes
    function automatic logic [EXP_W-1:0] expected_response(
        input opcode_e           op,
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] wdata,
        input logic [TXN_W-1:0]  txnid
    );
        logic              bad;
        logic [DATA_W-1:0] data;
        bad  = (int'(addr_block(addr)) >= NUM_BLOCKS);
        data = '0;
        if (!bad && op == OP_WRITE) begin
            model_mem[addr] = wdata;
            data = wdata;
        end else if (!bad) begin
            data = model_mem[addr];
        end
        return {op, bad, txnid, data};
    endfunction

    function automatic logic [ADDR_W-1:0] in_range(input logic [31:0] r);
        logic [ADDR_W-1:0] addr;
        addr = r[ADDR_W-1:0];
        if (int'(addr_block(addr)) >= NUM_BLOCKS) begin
            addr[ADDR_W-1 -: BLK_W] = '0;
        end
        return addr;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("error: %s at %0t", msg, $time);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accept edge
    task automatic send(input opcode_e op, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata, input logic [TXN_W-1:0] txnid);
        logic [EXP_W-1:0] exp;
        exp = expected_response(op, addr, wdata, txnid);
        if (addr_lane(addr)) begin
            exp_q1.push_back(exp);
        end else begin
            exp_q0.push_back(exp);
        end
        req_vld    = 1'b1;
        req_opcode = op;
        req_addr   = addr;
        req_wdata  = wdata;
        req_txnid  = txnid;
        @(posedge clk);
        #1;
    endtask

    task automatic stop_requests();
        req_vld = 1'b0;
    endtask

    task automatic expect_quiet();
        check_val("rsp_vld[0]", 64'(rsp_vld[0]), 64'(0));
        check_val("rsp_vld[1]", 64'(rsp_vld[1]), 64'(0));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q0.size() + exp_q1.size()) != 0 && n < DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if ((exp_q0.size() + exp_q1.size()) != 0) begin
            note_failure($sformatf("%0d responses never arrived",
                                   exp_q0.size() + exp_q1.size()));
            exp_q0.delete();
            exp_q1.delete();
        end
    endtask

    task automatic apply_reset();
        int n;
        rst_n   = 1'b0;
        req_vld = 1'b0;
        exp_q0.delete();   // in-flight items are dropped by the DUT
        exp_q1.delete();
        for (n = 0; n < RESET_CYCLES; n++) begin
            @(negedge clk);
            expect_quiet();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (n = 0; n < 2; n++) begin
            @(negedge clk);
            expect_quiet();
        end
        @(posedge clk);
        #1;
    endtask

    // request presented after edge e0, response must show after edge e0 + 1 + NUM_BLOCKS
    task automatic measure_latency(input opcode_e op, input logic [ADDR_W-1:0] addr);
        int lane;
        int k;
        int seen;
        lane = int'(addr_lane(addr));
        seen = 0;
        send(op, addr, rand32(), TXN_W'(rand32() >> 24));
        stop_requests();
        for (k = 1; k <= 2 * NUM_BLOCKS + 4; k++) begin
            @(negedge clk);
            check_val($sformatf("rsp_vld[%0d]", 1 - lane), 64'(rsp_vld[1 - lane]), 64'(0));
            if (rsp_vld[lane] && seen == 0) begin
                seen = k;
            end
        end
        if (seen == 0) begin
            note_failure($sformatf("no response on lane %0d for an isolated request", lane));
        end else begin
            check_val("latency", 64'(seen), 64'(1 + NUM_BLOCKS));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compare_response(input int lane);
        logic [EXP_W-1:0] exp;
        if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0)) begin
            note_failure($sformatf("response on lane %0d with no request pending", lane));
            return;
        end
        if (lane == 0) begin
            exp = exp_q0.pop_front();
        end else begin
            exp = exp_q1.pop_front();
        end
        check_val($sformatf("rsp_opcode[%0d]", lane), 64'(rsp_opcode[lane]),
                  64'(exp[EXP_W-1]));
        check_val($sformatf("rsp_err[%0d]", lane), 64'(rsp_err[lane]), 64'(exp[EXP_W-2]));
        check_val($sformatf("rsp_txnid[%0d]", lane), 64'(rsp_txnid[lane]),
                  64'(exp[DATA_W +: TXN_W]));
        check_val($sformatf("rsp_data[%0d]", lane), 64'(rsp_data[lane]),
                  64'(exp[DATA_W-1:0]));
    endtask

    initial begin : compare_responses
        int lane;
        forever begin
            @(negedge clk);   // rsp is stable mid-cycle
            if (rst_n) begin
                for (lane = 0; lane < LANES; lane++) begin
                    if (rsp_vld[lane] === 1'b1) begin
                        compare_response(lane);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main_flow
        int                errs;
        int                a;
        int                i;
        int                raw_pairs;
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] prev_addr;
        opcode_e           op;
        logic              prev_write;

        rst_n      = 1'b0;
        req_vld    = 1'b0;
        req_opcode = OP_READ;
        req_addr   = '0;
        req_wdata  = '0;
        req_txnid  = '0;
        rng_state  = 32'h105ee88a;
        checks     = 0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        for (a = 0; a < 2 ** ADDR_W; a++) begin
            model_mem[a] = '0;
        end

        errs = errors;
        apply_reset();
        finish_test("power_on_reset", errs);

        errs = errors;
        for (a = 0; a < VALID_ADDRS; a++) begin
            send(OP_WRITE, ADDR_W'(a), rand32(), 8'(a));
        end
        for (a = 0; a < VALID_ADDRS; a++) begin
            send(OP_READ, ADDR_W'(a), rand32(), 8'(a + 100));
        end
        stop_requests();
        wait_drain();
        finish_test("fill_readback", errs);

        errs = errors;
        measure_latency(OP_WRITE, {BLK_W'(0), ROW_W'(5), 1'b0});
        measure_latency(OP_READ,  {BLK_W'(0), ROW_W'(5), 1'b0});
        measure_latency(OP_WRITE, {BLK_W'(2), ROW_W'(9), 1'b1});
        measure_latency(OP_READ,  {BLK_W'(2), ROW_W'(9), 1'b1});
        finish_test("fixed_latency", errs);

        errs = errors;
        raw_pairs  = 0;
        prev_write = 1'b0;
        prev_addr  = '0;
        for (i = 0; i < RAND_REQS; i++) begin
            r = rand32();
            if (prev_write && r[2:0] < 3'd3) begin
                op   = OP_READ;   // read right behind the write
                addr = prev_addr;
                raw_pairs++;
            end else begin
                op   = r[3] ? OP_WRITE : OP_READ;
                addr = r[4 +: ADDR_W];
            end
            send(op, addr, rand32(), r[31:24]);
            prev_write = (op == OP_WRITE);
            prev_addr  = addr;
        end
        stop_requests();
        wait_drain();
        if (raw_pairs == 0) begin
            note_failure("random mix produced no read-after-write pair");
        end
        finish_test("random_mix", errs);

        errs = errors;
        for (i = 0; i < OOR_REQS; i++) begin
            r    = rand32();
            op   = i[1] ? OP_WRITE : OP_READ;
            addr = {BLK_W'(3), r[ROW_W-1:0], i[0]};
            send(op, addr, r | 32'h1, r[31:24]);
        end
        for (a = 0; a < VALID_ADDRS; a++) begin
            send(OP_READ, ADDR_W'(a), rand32(), 8'(a));
        end
        stop_requests();
        wait_drain();
        finish_test("out_of_range", errs);

        errs = errors;
        for (i = 0; i < CUT_REQS; i++) begin
            send(OP_READ, in_range(rand32()), rand32(), 8'(i));
        end
        apply_reset();   // last reads still inside the chain
        for (i = 0; i < 2 * NUM_BLOCKS + 4; i++) begin
            @(negedge clk);
            expect_quiet();
        end
        @(posedge clk);
        #1;
        for (i = 0; i < 4; i++) begin
            send(OP_READ, in_range(rand32()), rand32(), 8'(200 + i));
        end
        stop_requests();
        wait_drain();
        finish_test("mid_run_reset", errs);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vcache_ring.f ====
common/vcache_pkg.sv
mem_block/bank_sram.sv
mem_block/mem_block.sv
src/req_router.sv
src/vcache_ring_top.sv
tb/vcache_ring_sva.sv
tb/tb_vcache_ring.sv

// ==== run.sh ====
#!/bin/sh
# build and run the vcache_ring testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_vcache_ring -f vcache_ring.f -o sim_vcache_ring
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_vcache_ring)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
